// ==== rtl/xbar_macros.svh ====
`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

// channel and bank counts
`define XBAR_NUM_CH        3
`define XBAR_NUM_BANK      4

// request fields
`define XBAR_ADDR_LSB      4
`define XBAR_ADDR_W        28
`define XBAR_DATA_W        128
`define XBAR_BANK_SEL_W    2
`define XBAR_CH_ID_W       2

// write buffer ids, 32 per bank
`define XBAR_WBUF_AW       5
`define XBAR_WBUF_ID_W     8

`define XBAR_CH_BUF_DEPTH  2

`endif

// ==== rtl/xbar_pkg.sv ====
`include "xbar_macros.svh"

package xbar_pkg;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FLUSH = 2'd2,
    OP_RSVD  = 2'd3
  } xbar_op_e;

  // ----------------------------------------
  // channel side request
  // ----------------------------------------
  typedef struct packed {
    xbar_op_e                                                 op;
    logic [`XBAR_ADDR_LSB+`XBAR_ADDR_W-1:`XBAR_ADDR_LSB]      addr;
    logic [`XBAR_DATA_W-1:0]                                  data;
  } xbar_req_t;

  // ----------------------------------------
  // bank side request
  // ----------------------------------------
  typedef struct packed {
    logic [`XBAR_CH_ID_W-1:0]                                 ch_id;
    xbar_op_e                                                 op;
    logic [`XBAR_ADDR_LSB+`XBAR_ADDR_W-1:`XBAR_ADDR_LSB]      addr;
    logic [`XBAR_DATA_W-1:0]                                  data;
    // only meaningful for writes
    logic [`XBAR_WBUF_ID_W-1:0]                               wbuf_id;
  } bank_req_t;

endpackage

// ==== rtl/round_robin_arbiter.sv ====
`timescale 1ns/1ns

module round_robin_arbiter #(
  parameter int N = 3
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic [N-1:0]  req_i,
  input  logic          advance_i,
  output logic [N-1:0]  grant_o
);

  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(N - 1);

  logic [PTR_W-1:0]  prio_ptr;
  logic [PTR_W-1:0]  grant_idx;

  // first requester at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    grant_o   = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int i = 0; i < N; i++) begin
      idx = (int'(prio_ptr) + i) % N;
      if (!found && req_i[idx]) begin
        grant_o[idx] = 1'b1;
        grant_idx    = PTR_W'(idx);
        found        = 1'b1;
      end
    end
  end

  // winner drops to lowest priority
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_ptr <= '0;
    end else if (advance_i && (grant_o != '0)) begin
      prio_ptr <= (grant_idx == LAST_IDX) ? '0 : grant_idx + 1'b1;
    end
  end

  a_grant_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_o) && ((grant_o == '0) == (req_i == '0)));

endmodule

// ==== rtl/wbuffer_freelist.sv ====
`timescale 1ns/1ns

module wbuffer_freelist #(
  parameter int WBUFFER_AW = 5
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   alloc_i,
  output logic                   alloc_ready_o,
  output logic [WBUFFER_AW-1:0]  alloc_id_o,
  input  logic                   free_i,
  input  logic [WBUFFER_AW-1:0]  free_id_i
);

  localparam int DEPTH = 1 << WBUFFER_AW;
  localparam logic [WBUFFER_AW:0] FULL_CNT = (WBUFFER_AW + 1)'(DEPTH);

  logic [WBUFFER_AW-1:0]  id_mem [DEPTH];
  logic [WBUFFER_AW-1:0]  rd_ptr;
  logic [WBUFFER_AW-1:0]  wr_ptr;
  logic [WBUFFER_AW:0]    count;

  // ----------------------------------------
  // id queue, full of 0..DEPTH-1 after reset
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        id_mem[i] <= WBUFFER_AW'(i);
      end
      rd_ptr <= '0;
      // tail wraps back onto the head when full
      wr_ptr <= '0;
      count  <= FULL_CNT;
    end else begin
      if (free_i) begin
        id_mem[wr_ptr] <= free_id_i;
        wr_ptr         <= wr_ptr + 1'b1;
      end
      if (alloc_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({free_i, alloc_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign alloc_ready_o = (count != '0);
  assign alloc_id_o    = id_mem[rd_ptr];

  // the bank port must hold off writes while empty
  a_no_alloc_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_i |-> alloc_ready_o);

  // releases come from outside, only for ids handed out
  a_no_free_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    free_i |-> (count != FULL_CNT));

endmodule

// ==== rtl/xbar_ch_buffer.sv ====
`timescale 1ns/1ns
`include "xbar_macros.svh"

module xbar_ch_buffer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  xbar_pkg::xbar_req_t         req_i,
  output logic                        allow_in_o,
  output xbar_pkg::xbar_req_t         head_o,
  output logic [`XBAR_NUM_BANK-1:0]   want_o,
  input  logic [`XBAR_NUM_BANK-1:0]   taken_i
);

  localparam int DEPTH = `XBAR_CH_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  xbar_pkg::xbar_req_t          mem [DEPTH];
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  logic [CNT_W-1:0]             count;
  logic                         push;
  logic                         pop;
  logic [`XBAR_BANK_SEL_W-1:0]  bank_sel;

  // allow-in only looks at the stored count
  assign allow_in_o = (count != FULL_CNT);
  assign push       = valid_i & allow_in_o;
  assign pop        = |taken_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= req_i;
    end
  end

  // ----------------------------------------
  // head entry and bank decode
  // ----------------------------------------
  assign head_o   = mem[rd_ptr];
  // byte address bits 5:4
  assign bank_sel = head_o.addr[`XBAR_ADDR_LSB +: `XBAR_BANK_SEL_W];

  always_comb begin
    want_o = '0;
    if (count != '0) begin
      want_o[bank_sel] = 1'b1;
    end
  end

  // never more entries than slots, and a full queue has its tail on the head
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count <= FULL_CNT) && ((count != FULL_CNT) || (wr_ptr == rd_ptr)));

  // only the bank the head asked for may take it
  a_taken_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(taken_i) && ((taken_i & ~want_o) == '0));

endmodule

// ==== rtl/xbar_bank_port.sv ====
`timescale 1ns/1ns
`include "xbar_macros.svh"

module xbar_bank_port (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [`XBAR_NUM_CH-1:0]                   want_i,
  input  xbar_pkg::xbar_req_t [`XBAR_NUM_CH-1:0]    heads_i,
  input  logic                                      allow_in_i,
  input  logic                                      free_valid_i,
  input  logic [`XBAR_WBUF_AW-1:0]                  free_id_i,
  output logic                                      valid_o,
  output xbar_pkg::bank_req_t                       req_o,
  output logic [`XBAR_NUM_CH-1:0]                   taken_o
);

  logic [`XBAR_NUM_CH-1:0]   grant;
  xbar_pkg::xbar_req_t       sel_req;
  logic [`XBAR_CH_ID_W-1:0]  sel_ch;
  logic                      is_write;
  logic                      xfer;
  logic                      alloc;
  logic                      alloc_ready;
  logic [`XBAR_WBUF_AW-1:0]  alloc_id;

  round_robin_arbiter #(
    .N (`XBAR_NUM_CH)
  ) u_arbiter (
    .clk_i     (clk_i  ),
    .rst_n_i   (rst_n_i),
    .req_i     (want_i ),
    .advance_i (xfer   ),
    .grant_o   (grant  )
  );

  wbuffer_freelist #(
    .WBUFFER_AW (`XBAR_WBUF_AW)
  ) u_freelist (
    .clk_i         (clk_i       ),
    .rst_n_i       (rst_n_i     ),
    .alloc_i       (alloc       ),
    .alloc_ready_o (alloc_ready ),
    .alloc_id_o    (alloc_id    ),
    .free_i        (free_valid_i),
    .free_id_i     (free_id_i   )
  );

  // ----------------------------------------
  // grant mux
  // ----------------------------------------
  always_comb begin
    sel_req = '0;
    sel_ch  = '0;
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      if (grant[c]) begin
        sel_req = heads_i[c];
        sel_ch  = `XBAR_CH_ID_W'(c);
      end
    end
  end

  assign is_write = (sel_req.op == xbar_pkg::OP_WRITE);

  // a write waits here while no id is free
  assign valid_o = (|want_i) & (~is_write | alloc_ready);
  assign xfer    = valid_o & allow_in_i;
  assign alloc   = xfer & is_write;
  assign taken_o = xfer ? grant : '0;

  // ----------------------------------------
  // bank request
  // ----------------------------------------
  assign req_o.ch_id   = sel_ch;
  assign req_o.op      = sel_req.op;
  assign req_o.addr    = sel_req.addr;
  assign req_o.data    = sel_req.data;
  assign req_o.wbuf_id = is_write ?
                         {{(`XBAR_WBUF_ID_W - `XBAR_WBUF_AW){1'b0}}, alloc_id} : '0;

endmodule

// ==== rtl/cross_bar_core.sv ====
`timescale 1ns/1ns
`include "xbar_macros.svh"

module cross_bar_core (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // channels
  input  logic [`XBAR_NUM_CH-1:0]                       ch_valid_i,
  input  xbar_pkg::xbar_req_t [`XBAR_NUM_CH-1:0]        ch_req_i,
  output logic [`XBAR_NUM_CH-1:0]                       ch_allow_in_o,
  // banks
  output logic [`XBAR_NUM_BANK-1:0]                     bank_valid_o,
  output xbar_pkg::bank_req_t [`XBAR_NUM_BANK-1:0]      bank_req_o,
  input  logic [`XBAR_NUM_BANK-1:0]                     bank_allow_in_i,
  input  logic [`XBAR_NUM_BANK-1:0]                     bank_free_valid_i,
  input  logic [`XBAR_NUM_BANK-1:0][`XBAR_WBUF_AW-1:0]  bank_free_id_i
);

  xbar_pkg::xbar_req_t [`XBAR_NUM_CH-1:0]        heads;
  // row per channel, column per bank
  logic [`XBAR_NUM_CH-1:0][`XBAR_NUM_BANK-1:0]   want_row;
  logic [`XBAR_NUM_CH-1:0][`XBAR_NUM_BANK-1:0]   taken_row;
  logic [`XBAR_NUM_BANK-1:0][`XBAR_NUM_CH-1:0]   want_col;
  logic [`XBAR_NUM_BANK-1:0][`XBAR_NUM_CH-1:0]   taken_col;

  // ----------------------------------------
  // channel buffers
  // ----------------------------------------
  for (genvar c = 0; c < `XBAR_NUM_CH; c++) begin : g_ch
    xbar_ch_buffer u_ch_buffer (
      .clk_i      (clk_i           ),
      .rst_n_i    (rst_n_i         ),
      .valid_i    (ch_valid_i[c]   ),
      .req_i      (ch_req_i[c]     ),
      .allow_in_o (ch_allow_in_o[c]),
      .head_o     (heads[c]        ),
      .want_o     (want_row[c]     ),
      .taken_i    (taken_row[c]    )
    );

    for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_swap
      assign want_col[b][c]  = want_row[c][b];
      assign taken_row[c][b] = taken_col[b][c];
    end
  end

  // ----------------------------------------
  // bank ports
  // ----------------------------------------
  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_bank
    xbar_bank_port u_bank_port (
      .clk_i        (clk_i               ),
      .rst_n_i      (rst_n_i             ),
      .want_i       (want_col[b]         ),
      .heads_i      (heads               ),
      .allow_in_i   (bank_allow_in_i[b]  ),
      .free_valid_i (bank_free_valid_i[b]),
      .free_id_i    (bank_free_id_i[b]   ),
      .valid_o      (bank_valid_o[b]     ),
      .req_o        (bank_req_o[b]       ),
      .taken_o      (taken_col[b]        )
    );
  end

endmodule

// ==== test/tb_cross_bar_core.sv ====
`timescale 1ns/1ns
`include "xbar_macros.svh"

module tb_cross_bar_core;

  localparam int NCH        = `XBAR_NUM_CH;
  localparam int NB         = `XBAR_NUM_BANK;
  localparam int CHW        = `XBAR_CH_ID_W;
  localparam int ADDR_W     = `XBAR_ADDR_W;
  localparam int WBUF_AW    = `XBAR_WBUF_AW;
  localparam int NIDS       = 1 << WBUF_AW;
  localparam int DEPTH      = `XBAR_CH_BUF_DEPTH;
  localparam int CLK_PERIOD = 100;
  localparam int SEED       = 66504;
  localparam int ROUTE_N    = 20;
  localparam int RR_N       = 6;
  // rough cycle budget per test
  localparam int RESET_CYC  = 2 * 4;
  localparam int ROUTE_CYC  = 3 * ROUTE_N * 3;
  localparam int RR_CYC     = 3 * RR_N * 2;
  localparam int BP_CYC     = 8 * 3 + 12;
  localparam int WID_CYC    = 37 * 2 + 20;
  localparam int WATCHDOG_CYC = 2 * (RESET_CYC + ROUTE_CYC + RR_CYC + BP_CYC + WID_CYC);

  logic                                  clk_i;
  logic                                  rst_n_i;
  logic [NCH-1:0]                        ch_valid_i;
  xbar_pkg::xbar_req_t [NCH-1:0]         ch_req_i;
  logic [NCH-1:0]                        ch_allow_in_o;
  logic [NB-1:0]                         bank_valid_o;
  xbar_pkg::bank_req_t [NB-1:0]          bank_req_o;
  logic [NB-1:0]                         bank_allow_in_i;
  logic [NB-1:0]                         bank_free_valid_i;
  logic [NB-1:0][WBUF_AW-1:0]            bank_free_id_i;

  // reference model state
  xbar_pkg::xbar_req_t                   exp_q [NCH][$];
  logic [WBUF_AW-1:0]                    free_q [NB][$];
  int                                    rr_ptr [NB];
  int                                    exp_ch [NB];
  logic [NCH-1:0]                        exp_allow;
  logic [NB-1:0]                         exp_bvalid;
  xbar_pkg::bank_req_t                   exp_breq [NB];
  int                                    xfer_cnt = 0;

  int                                    err_cnt = 0;
  int                                    seq_err = 0;
  int                                    err_mark = 0;
  int                                    tests_run = 0;
  int                                    tests_bad = 0;
  logic                                  route_busy;

  cross_bar_core dut_i (
    .clk_i             (clk_i            ),
    .rst_n_i           (rst_n_i          ),
    .ch_valid_i        (ch_valid_i       ),
    .ch_req_i          (ch_req_i         ),
    .ch_allow_in_o     (ch_allow_in_o    ),
    .bank_valid_o      (bank_valid_o     ),
    .bank_req_o        (bank_req_o       ),
    .bank_allow_in_i   (bank_allow_in_i  ),
    .bank_free_valid_i (bank_free_valid_i),
    .bank_free_id_i    (bank_free_id_i   )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------
  // model update at the rising edge
  // ----------------------------------------
  always @(posedge clk_i) begin
    int ch;
    if (!rst_n_i) begin
      for (int c = 0; c < NCH; c++) begin
        exp_q[c].delete();
      end
      for (int b = 0; b < NB; b++) begin
        free_q[b].delete();
        for (int i = 0; i < NIDS; i++) begin
          free_q[b].push_back(WBUF_AW'(i));
        end
        rr_ptr[b] = 0;
      end
    end else begin
      for (int b = 0; b < NB; b++) begin
        if (exp_bvalid[b] && bank_allow_in_i[b]) begin
          ch = exp_ch[b];
          if (exp_q[ch][0].op == xbar_pkg::OP_WRITE) begin
            void'(free_q[b].pop_front());
          end
          void'(exp_q[ch].pop_front());
          rr_ptr[b] = (ch + 1) % NCH;
        end
      end
      for (int b = 0; b < NB; b++) begin
        if (bank_free_valid_i[b]) begin
          free_q[b].push_back(bank_free_id_i[b]);
        end
      end
      for (int c = 0; c < NCH; c++) begin
        if (ch_valid_i[c] && exp_allow[c]) begin
          exp_q[c].push_back(ch_req_i[c]);
        end
      end
    end
  end

  // bank transfers seen at the DUT outputs, counted ahead of their edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int b = 0; b < NB; b++) begin
        if (bank_valid_o[b] && bank_allow_in_i[b]) begin
          xfer_cnt++;
        end
      end
    end
  end

  // expected outputs, stable from the falling edge on
  always @(negedge clk_i) begin
    logic [NB-1:0]        want [NCH];
    int                   idx;
    bit                   found;
    bit                   is_wr;
    xbar_pkg::xbar_req_t  head;
    xbar_pkg::bank_req_t  req;
    for (int c = 0; c < NCH; c++) begin
      exp_allow[c] = (exp_q[c].size() < DEPTH);
      want[c] = '0;
      if (exp_q[c].size() != 0) begin
        // bank select is byte address bits 5:4
        want[c][exp_q[c][0].addr[5:4]] = 1'b1;
      end
    end
    for (int b = 0; b < NB; b++) begin
      found = 1'b0;
      exp_ch[b] = 0;
      head = '0;
      for (int i = 0; i < NCH; i++) begin
        idx = (rr_ptr[b] + i) % NCH;
        if (!found && want[idx][b]) begin
          found = 1'b1;
          exp_ch[b] = idx;
          head = exp_q[idx][0];
        end
      end
      is_wr = found && (head.op == xbar_pkg::OP_WRITE);
      exp_bvalid[b] = found && (!is_wr || (free_q[b].size() != 0));
      req.ch_id   = CHW'(exp_ch[b]);
      req.op      = head.op;
      req.addr    = head.addr;
      req.data    = head.data;
      req.wbuf_id = '0;
      if (is_wr && (free_q[b].size() != 0)) begin
        req.wbuf_id[WBUF_AW-1:0] = free_q[b][0];
      end
      exp_breq[b] = req;
    end
  end

  // ----------------------------------------
  // checks against the model
  // ----------------------------------------
  for (genvar b = 0; b < NB; b++) begin : g_bank_chk
    a_bank_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bank_valid_o[b] == exp_bvalid[b])
      else begin
        err_cnt++;
        $display("ERR t=%0t bank_valid_o[%0d] exp=%0b act=%0b", $time, b,
                 $sampled(exp_bvalid[b]), $sampled(bank_valid_o[b]));
      end

    a_bank_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      exp_bvalid[b] && bank_allow_in_i[b] |-> bank_req_o[b] == exp_breq[b])
      else begin
        err_cnt++;
        $display("ERR t=%0t bank_req_o[%0d] exp=%h act=%h", $time, b,
                 $sampled(exp_breq[b]), $sampled(bank_req_o[b]));
      end
  end

  for (genvar c = 0; c < NCH; c++) begin : g_ch_chk
    a_ch_allow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ch_allow_in_o[c] == exp_allow[c])
      else begin
        err_cnt++;
        $display("ERR t=%0t ch_allow_in_o[%0d] exp=%0b act=%0b", $time, c,
                 $sampled(exp_allow[c]), $sampled(ch_allow_in_o[c]));
      end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  function automatic xbar_pkg::xbar_req_t make_req(input xbar_pkg::xbar_op_e op,
                                                   input int bank);
    xbar_pkg::xbar_req_t r;
    r.op        = op;
    r.addr      = ADDR_W'($urandom());
    r.addr[5:4] = 2'(bank);
    r.data      = {$urandom(), $urandom(), $urandom(), $urandom()};
    return r;
  endfunction

  function automatic bit pending();
    bit busy;
    busy = 1'b0;
    for (int c = 0; c < NCH; c++) begin
      if (exp_q[c].size() != 0) begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  // entered and left 10 ns after a rising edge
  task automatic send_req(input int c, input xbar_pkg::xbar_req_t req);
    ch_valid_i[c] = 1'b1;
    ch_req_i[c]   = req;
    @(posedge clk_i);
    while (!exp_allow[c]) @(posedge clk_i);
    #10;
    ch_valid_i[c] = 1'b0;
  endtask

  task automatic send_random(input int c, input int n);
    xbar_pkg::xbar_op_e op;
    for (int i = 0; i < n; i++) begin
      case ($urandom_range(2))
        0:       op = xbar_pkg::OP_READ;
        1:       op = xbar_pkg::OP_FLUSH;
        default: op = xbar_pkg::OP_RSVD;
      endcase
      send_req(c, make_req(op, int'($urandom_range(3))));
    end
  endtask

  task automatic send_fixed(input int c, input xbar_pkg::xbar_op_e op, input int bank,
                            input int n);
    for (int i = 0; i < n; i++) begin
      send_req(c, make_req(op, bank));
    end
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
  endtask

  task automatic wait_drain();
    while (pending()) @(negedge clk_i);
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_count(input int base, input int n);
    assert (xfer_cnt - base == n)
      else begin
        seq_err++;
        $display("ERR t=%0t xfer_cnt exp=%0d act=%0d", $time, n, xfer_cnt - base);
      end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_cnt + seq_err - err_mark;
    err_mark = err_cnt + seq_err;
    tests_run++;
    if (errs != 0) begin
      tests_bad++;
    end
    $display("test %-12s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    int base;
    int total;
    void'($urandom(SEED));
    clk_i             = 1'b0;
    rst_n_i           = 1'b0;
    ch_valid_i        = '0;
    ch_req_i          = '0;
    bank_allow_in_i   = '0;
    bank_free_valid_i = '0;
    bank_free_id_i    = '0;
    route_busy        = 1'b0;

    apply_reset();
    @(negedge clk_i);
    assert (ch_allow_in_o == '1)
      else begin
        seq_err++;
        $display("ERR t=%0t ch_allow_in_o exp=%b act=%b", $time, {NCH{1'b1}}, ch_allow_in_o);
      end
    assert (bank_valid_o == '0)
      else begin
        seq_err++;
        $display("ERR t=%0t bank_valid_o exp=%b act=%b", $time, {NB{1'b0}}, bank_valid_o);
      end
    @(posedge clk_i);
    #10;
    finish_test("reset");

    // random traffic, random bank stalls
    base = xfer_cnt;
    route_busy = 1'b1;
    fork
      begin
        fork
          send_random(0, ROUTE_N);
          send_random(1, ROUTE_N);
          send_random(2, ROUTE_N);
        join
        route_busy = 1'b0;
      end
      begin
        while (route_busy) begin
          bank_allow_in_i = NB'($urandom());
          @(posedge clk_i);
          #10;
        end
        bank_allow_in_i = '1;
      end
    join
    wait_drain();
    check_count(base, 3 * ROUTE_N);
    finish_test("routing");

    // all channels on bank 2, fresh pointers
    apply_reset();
    bank_allow_in_i = '1;
    base = xfer_cnt;
    fork
      send_fixed(0, xbar_pkg::OP_READ, 2, RR_N);
      send_fixed(1, xbar_pkg::OP_READ, 2, RR_N);
      send_fixed(2, xbar_pkg::OP_READ, 2, RR_N);
    join
    wait_drain();
    check_count(base, 3 * RR_N);
    finish_test("round_robin");

    // bank 1 stalled
    bank_allow_in_i = 4'b1101;
    base = xfer_cnt;
    fork
      send_fixed(1, xbar_pkg::OP_READ, 1, 5);
      send_fixed(0, xbar_pkg::OP_FLUSH, 3, 3);
      begin
        while (exp_q[1].size() < DEPTH) @(negedge clk_i);
        repeat (4) @(negedge clk_i);
        assert (ch_allow_in_o[1] == 1'b0)
          else begin
            seq_err++;
            $display("ERR t=%0t ch_allow_in_o[1] exp=0 act=%0b", $time, ch_allow_in_o[1]);
          end
        @(posedge clk_i);
        #10;
        bank_allow_in_i[1] = 1'b1;
      end
    join
    wait_drain();
    check_count(base, 8);
    finish_test("backpressure");

    // 33 writes and 4 reads on bank 0
    bank_allow_in_i = '1;
    base = xfer_cnt;
    fork
      begin
        for (int i = 0; i < 37; i++) begin
          send_req(2, make_req((i % 9 == 4) ? xbar_pkg::OP_READ : xbar_pkg::OP_WRITE, 0));
        end
      end
      begin
        while ((free_q[0].size() != 0) || (exp_q[2].size() == 0)) @(negedge clk_i);
        repeat (5) @(negedge clk_i);
        assert (bank_valid_o[0] == 1'b0)
          else begin
            seq_err++;
            $display("ERR t=%0t bank_valid_o[0] exp=0 act=%0b", $time, bank_valid_o[0]);
          end
        @(posedge clk_i);
        #10;
        bank_free_valid_i[0] = 1'b1;
        bank_free_id_i[0]    = WBUF_AW'(7);
        @(posedge clk_i);
        #10;
        bank_free_valid_i[0] = 1'b0;
      end
    join
    wait_drain();
    check_count(base, 37);
    finish_test("write_ids");

    @(negedge clk_i);
    total = err_cnt + seq_err;
    $display("summary: %0d tests, %0d failed, %0d errors, %0d bank transfers",
             tests_run, tests_bad, total, xfer_cnt);
    if ((total == 0) && (tests_bad == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/xbar_pkg.sv
rtl/round_robin_arbiter.sv
rtl/wbuffer_freelist.sv
rtl/xbar_ch_buffer.sv
rtl/xbar_bank_port.sv
rtl/cross_bar_core.sv
test/tb_cross_bar_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_cross_bar_core \
  -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
exit 0
